// File: verilog.f
common/id_pkg.sv
decode/inst_decoder.sv
verilog/operand_forward.sv
verilog/operand_combine.sv
verilog/id_stage.sv
test/tb_clk_gen.sv
test/id_stage_tb.sv

// File: test/id_stage_tb.sv
// Decode stage testbench
`timescale 1ns/1ps
`default_nettype none

module id_stage_tb
	import id_pkg::*;
();

	localparam bypass_t   no_byp   = '0;

	// Register-file words of the row being built
	reg_word_t  rf1_word = 32'hA5A5_1234;
	reg_word_t  rf2_word = 32'h5A5A_8765;

	logic       clk;
	logic       arst_n;
	inst_u      inst;
	reg_word_t  reg1_data;
	reg_word_t  reg2_data;
	bypass_t    ex_byp;
	bypass_t    mem_byp;
	logic       reg1_read;
	logic       reg2_read;
	reg_addr_t  reg1_addr;
	reg_addr_t  reg2_addr;
	ex_bundle_t ex_bundle;

	// Stimulus and expected values per row
	string      names [64];
	inst_u      insts [64];
	reg_word_t  rf1s [64];
	reg_word_t  rf2s [64];
	bypass_t    ex_byps [64];
	bypass_t    mem_byps [64];
	reg_addr_t  exp_a1 [64];
	reg_addr_t  exp_a2 [64];
	logic [1:0] exp_en [64];
	ex_bundle_t exp_ex [64];
	int         n_entries = 0;

	int         bundle_errs = 0;
	int         addr_errs = 0;
	int         bit_errs = 0;
	ex_bundle_t nop_bundle;

	tb_clk_gen i_tb_clk_gen (
		.clk_o    (clk),
		.arst_n_o (arst_n)
	);

	id_stage i_id_stage (
		.clk         (clk),
		.arst_n_i    (arst_n),
		.inst_i      (inst),
		.reg1_data_i (reg1_data),
		.reg2_data_i (reg2_data),
		.reg1_read_o (reg1_read),
		.reg2_read_o (reg2_read),
		.reg1_addr_o (reg1_addr),
		.reg2_addr_o (reg2_addr),
		.ex_byp_i    (ex_byp),
		.mem_byp_i   (mem_byp),
		.ex_o        (ex_bundle)
	);

	function automatic inst_u encode_i(
		input logic [5:0]  op,
		input reg_addr_t   rs,
		input reg_addr_t   rt,
		input logic [15:0] imm
	);
		inst_u w;
		w.i_fmt.op    = op;
		w.i_fmt.rs    = rs;
		w.i_fmt.rt    = rt;
		w.i_fmt.imm16 = imm;
		return w;
	endfunction

	function automatic inst_u encode_r(
		input logic [5:0] func,
		input reg_addr_t  rs,
		input reg_addr_t  rt,
		input reg_addr_t  rd,
		input logic [4:0] sa
	);
		inst_u w;
		w.r_fmt.op   = op_special;
		w.r_fmt.rs   = rs;
		w.r_fmt.rt   = rt;
		w.r_fmt.rd   = rd;
		w.r_fmt.sa   = sa;
		w.r_fmt.func = func;
		return w;
	endfunction

	function automatic bypass_t bypass_of(
		input logic      wreg,
		input reg_addr_t wd,
		input reg_word_t wdata
	);
		bypass_t b;
		b.wreg  = wreg;
		b.wd    = wd;
		b.wdata = wdata;
		return b;
	endfunction

	function automatic ex_bundle_t expect_bundle(
		input aluop_e    aluop,
		input alusel_e   alusel,
		input reg_word_t reg1,
		input reg_word_t reg2,
		input reg_addr_t wd,
		input logic      wreg
	);
		ex_bundle_t b;
		b.aluop  = aluop;
		b.alusel = alusel;
		b.reg1   = reg1;
		b.reg2   = reg2;
		b.wd     = wd;
		b.wreg   = wreg;
		return b;
	endfunction

	task automatic add_entry(
		input string      name,
		input inst_u      w,
		input bypass_t    exb,
		input bypass_t    memb,
		input logic [1:0] rd_en,
		input ex_bundle_t exp
	);
		names[n_entries]    = name;
		insts[n_entries]    = w;
		rf1s[n_entries]     = rf1_word;
		rf2s[n_entries]     = rf2_word;
		ex_byps[n_entries]  = exb;
		mem_byps[n_entries] = memb;
		// Read ports always carry rs and rt
		exp_a1[n_entries]   = w.r_fmt.rs;
		exp_a2[n_entries]   = w.r_fmt.rt;
		exp_en[n_entries]   = rd_en;
		exp_ex[n_entries]   = exp;
		n_entries++;
		// Fresh register-file data for the next row
		rf1_word = {rf1_word[26:0], rf1_word[31:27]};
		rf2_word = {rf2_word[26:0], rf2_word[31:27]};
	endtask

	// I-type writes rt and takes the immediate on port 2
	task automatic imm_row(
		input string       name,
		input logic [5:0]  op,
		input reg_addr_t   rt,
		input logic [15:0] imm,
		input reg_word_t   exp_imm,
		input aluop_e      aluop,
		input alusel_e     alusel
	);
		add_entry(name, encode_i(op, 5'd1, rt, imm), no_byp, no_byp, 2'b10,
			expect_bundle(aluop, alusel, rf1_word, exp_imm, rt, 1'b1));
	endtask

	task automatic reg_row(
		input string      name,
		input logic [5:0] func,
		input reg_addr_t  rd,
		input aluop_e     aluop,
		input alusel_e    alusel
	);
		add_entry(name, encode_r(func, 5'd1, 5'd2, rd, 5'd0), no_byp, no_byp, 2'b11,
			expect_bundle(aluop, alusel, rf1_word, rf2_word, rd, 1'b1));
	endtask

	// Shifts take the low half of the word as reg1
	task automatic shift_row(
		input string      name,
		input logic [5:0] func,
		input reg_addr_t  rd,
		input logic [4:0] sa,
		input reg_word_t  exp_r1,
		input aluop_e     aluop
	);
		add_entry(name, encode_r(func, 5'd0, 5'd2, rd, sa), no_byp, no_byp, 2'b01,
			expect_bundle(aluop, sel_shift, exp_r1, rf2_word, rd, 1'b1));
	endtask

	task automatic build_table();
		imm_row("ori_hi", op_ori, 5'd2, 16'h8001, 32'h0000_8001, alu_or, sel_logic);
		add_entry("bad_opcode", encode_i(6'b110011, 5'd3, 5'd4, 16'hFFFF), no_byp, no_byp,
			2'b00, nop_bundle);
		imm_row("ori_lo", op_ori, 5'd3, 16'h1234, 32'h0000_1234, alu_or, sel_logic);
		imm_row("andi_lo", op_andi, 5'd4, 16'h00F0, 32'h0000_00F0, alu_and, sel_logic);
		imm_row("andi_hi", op_andi, 5'd5, 16'hF0F0, 32'h0000_F0F0, alu_and, sel_logic);
		imm_row("xori_hi", op_xori, 5'd6, 16'hF00F, 32'h0000_F00F, alu_xor, sel_logic);
		imm_row("xori_lo", op_xori, 5'd8, 16'h0F0F, 32'h0000_0F0F, alu_xor, sel_logic);
		imm_row("lui_hi", op_lui, 5'd7, 16'h8765, 32'h0000_8765, alu_lui, sel_logic);
		imm_row("lui_lo", op_lui, 5'd11, 16'h1234, 32'h0000_1234, alu_lui, sel_logic);
		imm_row("addi_hi", op_addi, 5'd9, 16'hFFFE, 32'hFFFF_FFFE, alu_addi, sel_math);
		imm_row("addi_lo", op_addi, 5'd10, 16'h7FFE, 32'h0000_7FFE, alu_addi, sel_math);
		imm_row("addiu_hi", op_addiu, 5'd12, 16'h8000, 32'hFFFF_8000, alu_addiu, sel_math);
		imm_row("addiu_lo", op_addiu, 5'd13, 16'h0042, 32'h0000_0042, alu_addiu, sel_math);
		imm_row("slti_hi", op_slti, 5'd15, 16'hC000, 32'hFFFF_C000, alu_slt, sel_math);
		imm_row("slti_lo", op_slti, 5'd16, 16'h1000, 32'h0000_1000, alu_slt, sel_math);
		imm_row("sltiu_hi", op_sltiu, 5'd18, 16'h9000, 32'h0000_9000, alu_sltu, sel_math);
		imm_row("sltiu_lo", op_sltiu, 5'd19, 16'h0123, 32'h0000_0123, alu_sltu, sel_math);
		reg_row("and", fn_and, 5'd3, alu_and, sel_logic);
		reg_row("or", fn_or, 5'd4, alu_or, sel_logic);
		reg_row("xor", fn_xor, 5'd5, alu_xor, sel_logic);
		reg_row("nor", fn_nor, 5'd6, alu_nor, sel_logic);
		reg_row("sllv", fn_sllv, 5'd7, alu_sllv, sel_shift);
		reg_row("srlv", fn_srlv, 5'd8, alu_srlv, sel_shift);
		reg_row("srav", fn_srav, 5'd9, alu_srav, sel_shift);
		shift_row("sll", fn_sll, 5'd3, 5'd4, 32'h0000_1900, alu_sll);
		shift_row("srl", fn_srl, 5'd4, 5'd1, 32'h0000_2042, alu_srl);
		shift_row("sra", fn_sra, 5'd5, 5'd31, 32'h0000_2FC3, alu_sra);
		reg_row("add", fn_add, 5'd10, alu_add, sel_math);
		add_entry("bad_func", encode_r(6'b001111, 5'd5, 5'd6, 5'd7, 5'd0), no_byp, no_byp,
			2'b00, nop_bundle);
		reg_row("addu", fn_addu, 5'd11, alu_addu, sel_math);
		reg_row("sub", fn_sub, 5'd12, alu_sub, sel_math);
		reg_row("subu", fn_subu, 5'd13, alu_subu, sel_math);
		reg_row("slt", fn_slt, 5'd14, alu_slt, sel_math);
		reg_row("sltu", fn_sltu, 5'd15, alu_sltu, sel_math);
		// Conditional moves test the forwarded rt word
		add_entry("movn_zero", encode_r(fn_movn, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b1, 5'd2, 32'h0), no_byp,
			2'b11, expect_bundle(alu_movn, sel_move, rf1_word, 32'h0, 5'd3, 1'b0));
		add_entry("movn_nonzero", encode_r(fn_movn, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b1, 5'd2, 32'h0000_0080), no_byp,
			2'b11, expect_bundle(alu_movn, sel_move, rf1_word, 32'h0000_0080, 5'd3, 1'b1));
		add_entry("movz_zero", encode_r(fn_movz, 5'd1, 5'd2, 5'd4, 5'd0),
			no_byp, bypass_of(1'b1, 5'd2, 32'h0),
			2'b11, expect_bundle(alu_movz, sel_move, rf1_word, 32'h0, 5'd4, 1'b1));
		add_entry("movz_nonzero", encode_r(fn_movz, 5'd1, 5'd2, 5'd4, 5'd0),
			no_byp, no_byp,
			2'b11, expect_bundle(alu_movz, sel_move, rf1_word, rf2_word, 5'd4, 1'b0));
		// Execute result is younger than memory
		add_entry("fwd1_ex_over_mem", encode_r(fn_or, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b1, 5'd1, 32'hEEEE_0001), bypass_of(1'b1, 5'd1, 32'hCCCC_0001),
			2'b11, expect_bundle(alu_or, sel_logic, 32'hEEEE_0001, rf2_word, 5'd3, 1'b1));
		add_entry("fwd1_mem", encode_r(fn_or, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b1, 5'd5, 32'hEEEE_0001), bypass_of(1'b1, 5'd1, 32'hCCCC_0001),
			2'b11, expect_bundle(alu_or, sel_logic, 32'hCCCC_0001, rf2_word, 5'd3, 1'b1));
		add_entry("fwd2_ex_over_mem", encode_r(fn_or, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b1, 5'd2, 32'hEEEE_0002), bypass_of(1'b1, 5'd2, 32'hCCCC_0002),
			2'b11, expect_bundle(alu_or, sel_logic, rf1_word, 32'hEEEE_0002, 5'd3, 1'b1));
		add_entry("fwd2_mem", encode_r(fn_or, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b0, 5'd2, 32'hEEEE_0002), bypass_of(1'b1, 5'd2, 32'hCCCC_0002),
			2'b11, expect_bundle(alu_or, sel_logic, rf1_word, 32'hCCCC_0002, 5'd3, 1'b1));
		add_entry("fwd_none", encode_r(fn_or, 5'd1, 5'd2, 5'd3, 5'd0),
			bypass_of(1'b0, 5'd1, 32'hEEEE_0001), bypass_of(1'b0, 5'd2, 32'hCCCC_0002),
			2'b11, expect_bundle(alu_or, sel_logic, rf1_word, rf2_word, 5'd3, 1'b1));
	endtask

	task automatic check_bundle(input string name, input ex_bundle_t exp, input ex_bundle_t act);
		if (act !== exp)
		begin
			$display("Mismatch %s ex_o: expected %h, actual %h", name, exp, act);
			bundle_errs++;
		end
	endtask

	task automatic check_addr(
		input string     name,
		input string     port,
		input reg_addr_t exp,
		input reg_addr_t act
	);
		if (act !== exp)
		begin
			$display("Mismatch %s %s: expected %0d, actual %0d", name, port, exp, act);
			addr_errs++;
		end
	endtask

	task automatic check_bit(
		input string name,
		input string port,
		input logic  exp,
		input logic  act
	);
		if (act !== exp)
		begin
			$display("Mismatch %s %s: expected %b, actual %b", name, port, exp, act);
			bit_errs++;
		end
	endtask

	initial
	begin
		// Opcode 111111 decodes as invalid and leaves a NOP behind reset
		inst       = 32'hFC00_0000;
		reg1_data  = rf1_word;
		reg2_data  = rf2_word;
		ex_byp     = '0;
		mem_byp    = '0;
		nop_bundle = expect_bundle(alu_nop, sel_nop, 32'h0, 32'h0, 5'd0, 1'b0);
		build_table();

		@(negedge clk);
		check_bundle("in_reset", nop_bundle, ex_bundle);
		wait (arst_n == 1'b1);
		repeat (2) @(negedge clk);
		check_bundle("after_reset", nop_bundle, ex_bundle);

		// ex_o of one row is checked while the next row decodes
		for (int i = 0; i < n_entries; i++)
		begin
			@(posedge clk);
			inst      <= insts[i];
			reg1_data <= rf1s[i];
			reg2_data <= rf2s[i];
			ex_byp    <= ex_byps[i];
			mem_byp   <= mem_byps[i];
			@(negedge clk);
			check_addr(names[i], "reg1_addr", exp_a1[i], reg1_addr);
			check_addr(names[i], "reg2_addr", exp_a2[i], reg2_addr);
			check_bit(names[i], "reg1_read", exp_en[i][1], reg1_read);
			check_bit(names[i], "reg2_read", exp_en[i][0], reg2_read);
			if (i > 0)
				check_bundle(names[i - 1], exp_ex[i - 1], ex_bundle);
		end
		@(posedge clk);
		@(negedge clk);
		check_bundle(names[n_entries - 1], exp_ex[n_entries - 1], ex_bundle);

		$display("Errors: %0d bundle, %0d address, %0d enable", bundle_errs, addr_errs, bit_errs);
		if (bundle_errs + addr_errs + bit_errs == 0)
			$display("=== PASS ===");
		else
			$display("=== FAIL ===");
		$finish;
	end

	// Watchdog at four times the expected run length
	initial
	begin
		#1;
		#((n_entries + 10) * 8 * 4);
		$display("Timeout: the run hung before all entries were checked");
		$display("=== FAIL ===");
		$finish;
	end

endmodule

`default_nettype wire

// File: test/tb_clk_gen.sv
// Testbench clock and reset
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen (
	output logic clk_o,
	output logic arst_n_o
);

	// 8 ns period
	initial
	begin
		clk_o = 1'b0;
		forever #4 clk_o = ~clk_o;
	end

	// Reset held over the first four rising edges
	initial
	begin
		arst_n_o = 1'b0;
		repeat (4) @(posedge clk_o);
		arst_n_o <= 1'b1;
	end

endmodule

`default_nettype wire

// File: verilog/id_stage.sv
// Instruction decode stage
`timescale 1ns/1ps
`default_nettype none

module id_stage
	import id_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n_i,
	input  inst_u      inst_i,

	// Register file read side
	input  reg_word_t  reg1_data_i,
	input  reg_word_t  reg2_data_i,
	output logic       reg1_read_o,
	output logic       reg2_read_o,
	output reg_addr_t  reg1_addr_o,
	output reg_addr_t  reg2_addr_o,

	// Results from execute and memory
	input  bypass_t    ex_byp_i,
	input  bypass_t    mem_byp_i,

	output ex_bundle_t ex_o
);

	dec_ctrl_t ctrl;
	reg_word_t fwd1;
	reg_word_t fwd2;

	inst_decoder i_inst_decoder (
		.inst_i      (inst_i),
		.ctrl_o      (ctrl),
		.reg1_addr_o (reg1_addr_o),
		.reg2_addr_o (reg2_addr_o)
	);

	// Read enables leave through the top-level ports
	assign reg1_read_o = ctrl.reg1_read;
	assign reg2_read_o = ctrl.reg2_read;

	operand_forward i_operand_forward (
		.reg1_addr_i (reg1_addr_o),
		.reg2_addr_i (reg2_addr_o),
		.reg1_data_i (reg1_data_i),
		.reg2_data_i (reg2_data_i),
		.ex_byp_i    (ex_byp_i),
		.mem_byp_i   (mem_byp_i),
		.fwd1_o      (fwd1),
		.fwd2_o      (fwd2)
	);

	operand_combine i_operand_combine (
		.clk      (clk),
		.arst_n_i (arst_n_i),
		.ctrl_i   (ctrl),
		.fwd1_i   (fwd1),
		.fwd2_i   (fwd2),
		.ex_o     (ex_o)
	);

endmodule

`default_nettype wire

// File: verilog/operand_combine.sv
// Operand select and execute register
`timescale 1ns/1ps
`default_nettype none

module operand_combine
	import id_pkg::*;
(
	input  wire        clk,
	input  wire        arst_n_i,
	input  dec_ctrl_t  ctrl_i,
	input  reg_word_t  fwd1_i,
	input  reg_word_t  fwd2_i,
	output ex_bundle_t ex_o
);

	reg_word_t reg1;
	reg_word_t reg2;
	logic      wreg;

	// Disabled port takes the immediate
	assign reg1 = ctrl_i.reg1_read ? fwd1_i : ctrl_i.imm;
	assign reg2 = ctrl_i.reg2_read ? fwd2_i : ctrl_i.imm;

	// MOVN and MOVZ test the forwarded rt value
	always_comb
	begin
		case (ctrl_i.wreg_mode)
			wr_always:
				wreg = 1'b1;
			wr_if_nonzero:
				wreg = (reg2 != '0);
			wr_if_zero:
				wreg = (reg2 == '0);
			default:
				wreg = 1'b0;
		endcase
	end

	// Decode/execute pipeline register
	always_ff @(posedge clk or negedge arst_n_i)
	begin
		if (!arst_n_i)
		begin
			ex_o.aluop  <= alu_nop;
			ex_o.alusel <= sel_nop;
			ex_o.reg1   <= '0;
			ex_o.reg2   <= '0;
			ex_o.wd     <= '0;
			ex_o.wreg   <= 1'b0;
		end
		else
		begin
			ex_o.aluop  <= ctrl_i.aluop;
			ex_o.alusel <= ctrl_i.alusel;
			ex_o.reg1   <= reg1;
			ex_o.reg2   <= reg2;
			ex_o.wd     <= ctrl_i.wd;
			ex_o.wreg   <= wreg;
		end
	end

endmodule

`default_nettype wire

// File: verilog/operand_forward.sv
// Operand bypass selection
`timescale 1ns/1ps
`default_nettype none

module operand_forward
	import id_pkg::*;
(
	input  reg_addr_t reg1_addr_i,
	input  reg_addr_t reg2_addr_i,
	input  reg_word_t reg1_data_i,
	input  reg_word_t reg2_data_i,
	input  bypass_t   ex_byp_i,
	input  bypass_t   mem_byp_i,
	output reg_word_t fwd1_o,
	output reg_word_t fwd2_o
);

	// Youngest result wins, register file last
	function automatic reg_word_t pick_word(
		input reg_addr_t addr,
		input reg_word_t rf_data,
		input bypass_t   ex_byp,
		input bypass_t   mem_byp
	);
		if (ex_byp.wreg && (ex_byp.wd == addr))
			return ex_byp.wdata;
		else if (mem_byp.wreg && (mem_byp.wd == addr))
			return mem_byp.wdata;
		else
			return rf_data;
	endfunction

	// Register 0 is matched like any other
	always_comb
	begin
		fwd1_o = pick_word(reg1_addr_i, reg1_data_i, ex_byp_i, mem_byp_i);
	end

	always_comb
	begin
		fwd2_o = pick_word(reg2_addr_i, reg2_data_i, ex_byp_i, mem_byp_i);
	end

endmodule

`default_nettype wire

// File: decode/inst_decoder.sv
// Opcode and function decoder
`timescale 1ns/1ps
`default_nettype none

module inst_decoder
	import id_pkg::*;
(
	input  inst_u     inst_i,
	output dec_ctrl_t ctrl_o,
	output reg_addr_t reg1_addr_o,
	output reg_addr_t reg2_addr_o
);

	aluop_e  aluop;
	alusel_e alusel;
	logic    valid;
	logic    is_special;
	logic    shift_imm;
	logic    sign_ext;

	// Ports always address rs and rt
	assign reg1_addr_o = inst_i.r_fmt.rs;
	assign reg2_addr_o = inst_i.i_fmt.rt;

	// Operation from opcode, or from func under SPECIAL
	always_comb
	begin
		aluop = alu_nop;
		case (inst_i.i_fmt.op)
			op_ori:   aluop = alu_or;
			op_andi:  aluop = alu_and;
			op_xori:  aluop = alu_xor;
			op_lui:   aluop = alu_lui;
			op_addi:  aluop = alu_addi;
			op_addiu: aluop = alu_addiu;
			op_slti:  aluop = alu_slt;
			op_sltiu: aluop = alu_sltu;
			op_special:
			begin
				case (inst_i.r_fmt.func)
					fn_and:  aluop = alu_and;
					fn_or:   aluop = alu_or;
					fn_xor:  aluop = alu_xor;
					fn_nor:  aluop = alu_nor;
					fn_sllv: aluop = alu_sllv;
					fn_srlv: aluop = alu_srlv;
					fn_srav: aluop = alu_srav;
					fn_sll:  aluop = alu_sll;
					fn_srl:  aluop = alu_srl;
					fn_sra:  aluop = alu_sra;
					fn_movn: aluop = alu_movn;
					fn_movz: aluop = alu_movz;
					fn_add:  aluop = alu_add;
					fn_addu: aluop = alu_addu;
					fn_sub:  aluop = alu_sub;
					fn_subu: aluop = alu_subu;
					fn_slt:  aluop = alu_slt;
					fn_sltu: aluop = alu_sltu;
					default: aluop = alu_nop;
				endcase
			end
			default:  aluop = alu_nop;
		endcase
	end

	// Result class follows the operation
	always_comb
	begin
		case (aluop)
			alu_and, alu_or, alu_xor, alu_nor, alu_lui:
				alusel = sel_logic;
			alu_sll, alu_srl, alu_sra, alu_sllv, alu_srlv, alu_srav:
				alusel = sel_shift;
			alu_movn, alu_movz:
				alusel = sel_move;
			alu_add, alu_addu, alu_sub, alu_subu, alu_addi, alu_addiu, alu_slt, alu_sltu:
				alusel = sel_math;
			default:
				alusel = sel_nop;
		endcase
	end

	// Every kept instruction maps to a non-NOP code
	assign valid      = (aluop != alu_nop);
	assign is_special = (inst_i.r_fmt.op == op_special);

	// Shift amount comes in through the immediate
	assign shift_imm = is_special && ((aluop == alu_sll) || (aluop == alu_srl) ||
		(aluop == alu_sra));

	assign sign_ext = (inst_i.i_fmt.op == op_addi) || (inst_i.i_fmt.op == op_addiu) ||
		(inst_i.i_fmt.op == op_slti);

	assign ctrl_o.aluop     = aluop;
	assign ctrl_o.alusel    = alusel;
	assign ctrl_o.reg1_read = valid && !shift_imm;
	assign ctrl_o.reg2_read = valid && is_special;

	// R-type writes rd, I-type writes rt
	always_comb
	begin
		if (!valid)
			ctrl_o.wd = '0;
		else if (is_special)
			ctrl_o.wd = inst_i.r_fmt.rd;
		else
			ctrl_o.wd = inst_i.i_fmt.rt;
	end

	always_comb
	begin
		if (!valid)
			ctrl_o.wreg_mode = wr_never;
		else if (aluop == alu_movn)
			ctrl_o.wreg_mode = wr_if_nonzero;
		else if (aluop == alu_movz)
			ctrl_o.wreg_mode = wr_if_zero;
		else
			ctrl_o.wreg_mode = wr_always;
	end

	always_comb
	begin
		if (!valid)
			ctrl_o.imm = '0;
		else if (sign_ext)
			ctrl_o.imm = {{16{inst_i.i_fmt.imm16[15]}}, inst_i.i_fmt.imm16};
		else
			ctrl_o.imm = {16'h0000, inst_i.i_fmt.imm16};
	end

endmodule

`default_nettype wire

// File: common/id_pkg.sv
// Decode stage shared types
`default_nettype none

package id_pkg;

	typedef logic [31:0] reg_word_t;
	typedef logic [4:0]  reg_addr_t;

	// One instruction word seen as R-type or I-type
	typedef union packed {
		struct packed {
			logic [5:0] op;
			reg_addr_t  rs;
			reg_addr_t  rt;
			reg_addr_t  rd;
			logic [4:0] sa;
			logic [5:0] func;
		} r_fmt;
		struct packed {
			logic [5:0]  op;
			reg_addr_t   rs;
			reg_addr_t   rt;
			logic [15:0] imm16;
		} i_fmt;
	} inst_u;

	// Primary opcodes
	typedef enum logic [5:0] {
		op_special = 6'b000000,
		op_addi    = 6'b001000,
		op_addiu   = 6'b001001,
		op_slti    = 6'b001010,
		op_sltiu   = 6'b001011,
		op_andi    = 6'b001100,
		op_ori     = 6'b001101,
		op_xori    = 6'b001110,
		op_lui     = 6'b001111
	} opcode_e;

	// SPECIAL function field
	typedef enum logic [5:0] {
		fn_sll  = 6'b000000,
		fn_srl  = 6'b000010,
		fn_sra  = 6'b000011,
		fn_sllv = 6'b000100,
		fn_srlv = 6'b000110,
		fn_srav = 6'b000111,
		fn_movz = 6'b001010,
		fn_movn = 6'b001011,
		fn_add  = 6'b100000,
		fn_addu = 6'b100001,
		fn_sub  = 6'b100010,
		fn_subu = 6'b100011,
		fn_and  = 6'b100100,
		fn_or   = 6'b100101,
		fn_xor  = 6'b100110,
		fn_nor  = 6'b100111,
		fn_slt  = 6'b101010,
		fn_sltu = 6'b101011
	} func_e;

	// Operation sent to execute, SLTI/SLTIU reuse the SLT/SLTU codes
	typedef enum logic [7:0] {
		alu_nop   = 8'b00000000,
		alu_srl   = 8'b00000010,
		alu_sra   = 8'b00000011,
		alu_sllv  = 8'b00000100,
		alu_srlv  = 8'b00000110,
		alu_srav  = 8'b00000111,
		alu_movz  = 8'b00001010,
		alu_movn  = 8'b00001011,
		alu_add   = 8'b00100000,
		alu_addu  = 8'b00100001,
		alu_sub   = 8'b00100010,
		alu_subu  = 8'b00100011,
		alu_and   = 8'b00100100,
		alu_or    = 8'b00100101,
		alu_xor   = 8'b00100110,
		alu_nor   = 8'b00100111,
		alu_slt   = 8'b00101010,
		alu_sltu  = 8'b00101011,
		alu_addi  = 8'b01010101,
		alu_addiu = 8'b01010110,
		alu_lui   = 8'b01011100,
		alu_sll   = 8'b01111100
	} aluop_e;

	// Result class
	typedef enum logic [2:0] {
		sel_nop   = 3'b000,
		sel_logic = 3'b001,
		sel_shift = 3'b010,
		sel_move  = 3'b011,
		sel_math  = 3'b100
	} alusel_e;

	// Destination write rule
	typedef enum logic [1:0] {
		wr_never      = 2'b00,
		wr_always     = 2'b01,
		wr_if_nonzero = 2'b10,
		wr_if_zero    = 2'b11
	} wreg_mode_e;

	typedef struct packed {
		aluop_e     aluop;
		alusel_e    alusel;
		reg_addr_t  wd;
		wreg_mode_e wreg_mode;
		logic       reg1_read;
		logic       reg2_read;
		reg_word_t  imm;
	} dec_ctrl_t;

	// Result still in flight in a later stage
	typedef struct packed {
		logic      wreg;
		reg_addr_t wd;
		reg_word_t wdata;
	} bypass_t;

	typedef struct packed {
		aluop_e    aluop;
		alusel_e   alusel;
		reg_word_t reg1;
		reg_word_t reg2;
		reg_addr_t wd;
		logic      wreg;
	} ex_bundle_t;

endpackage

`default_nettype wire
